// File: hw/fetch_pkg.sv
package fetch_pkg;

  // Machine width for PCs and instruction words
  localparam int xlen = 32;

  // Major opcodes seen by the predecoder
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // Address issued to the instruction memory this cycle
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
  } fetch_req_t;

  // Memory response, one cycle behind the request
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } fetch_pkt_t;

  // B-type field layout, immediate bits scattered around the registers
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // J-type field layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One fetched word, read either as a branch or as a jump
  typedef union packed {
    logic [31:0] raw;
    b_fmt_t      b_view;
    j_fmt_t      j_view;
  } instr_u;

  // Static prediction result
  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } pred_t;

  // Everything the decode stage receives
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [31:0]     instr;
    pred_t           pred;
  } id_pkt_t;

endpackage

// File: hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         stall,
  input  logic                         redirect_valid,
  input  logic [fetch_pkg::xlen-1:0]   redirect_target,
  input  logic                         pkt_valid,
  input  fetch_pkg::pred_t             pred,
  output fetch_pkg::fetch_req_t        req,
  output logic                         squash
);

  // Current fetch address
  logic [fetch_pkg::xlen-1:0] pc_q;
  // Prediction accepted this cycle
  logic                       pred_take;
  logic [fetch_pkg::xlen-1:0] pc_next;

  // A prediction only counts when the front end moves and no redirect wins
  assign pred_take = pkt_valid & pred.taken & ~stall & ~redirect_valid;

  // Fall-through request in flight is wrong once a prediction is taken
  assign squash = pred_take;

  // Redirect first, then prediction, then sequential
  always_comb begin
    if (redirect_valid) begin
      pc_next = redirect_target;
    end else if (pred_take) begin
      pc_next = pred.target;
    end else begin
      pc_next = pc_q + fetch_pkg::xlen'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else begin
      // Redirect still lands during stall
      if (redirect_valid) begin
        pc_q <= pc_next;
      end else if (!stall) begin
        pc_q <= pc_next;
      end
    end
  end

  // Request goes straight from the PC register, issued every cycle
  assign req.valid = 1'b1;
  assign req.pc    = pc_q;

endmodule

// File: hw/imem_bram.sv
`timescale 1ns/1ps

module imem_bram #(
  parameter int IMEM_AW = 6
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall,
  input  logic                        redirect_valid,
  input  logic                        squash,
  input  fetch_pkg::fetch_req_t       req,
  input  logic                        we,
  input  logic [IMEM_AW-1:0]          waddr,
  input  logic [31:0]                 wdata,
  output fetch_pkg::fetch_pkt_t       pkt
);

  // Word-addressed storage
  logic [31:0] mem [2**IMEM_AW];

  logic [IMEM_AW-1:0]         raddr;
  logic                       valid_q;
  logic [fetch_pkg::xlen-1:0] pc_q;
  logic [31:0]                instr_q;

  // Byte PC down to word index, low two bits dropped
  assign raddr = req.pc[IMEM_AW+1:2];

  // Load port used before the program runs
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, held along with its PC under stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      instr_q <= mem[raddr];
      pc_q    <= req.pc;
    end
  end

  // Redirect also kills a packet held by stall, it is from the old path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (redirect_valid) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= req.valid & ~squash;
    end
  end

  assign pkt.valid = valid_q;
  assign pkt.pc    = pc_q;
  assign pkt.instr = instr_q;

endmodule

// File: hw/branch_predecode.sv
`timescale 1ns/1ps

module branch_predecode (
  input  fetch_pkg::fetch_pkt_t pkt,
  output fetch_pkg::pred_t      pred
);

  // Same word, seen as B and as J
  fetch_pkg::instr_u          iw;
  logic                       is_jal;
  logic                       is_branch;
  logic [fetch_pkg::xlen-1:0] b_off;
  logic [fetch_pkg::xlen-1:0] j_off;
  logic [fetch_pkg::xlen-1:0] off;

  assign iw = pkt.instr;

  // Opcode sits in the same place in both views
  assign is_jal    = (iw.j_view.opcode == fetch_pkg::opc_jal);
  assign is_branch = (iw.b_view.opcode == fetch_pkg::opc_branch);

  // B offset, 13 bits signed, bit 0 always zero
  assign b_off = {
    {(fetch_pkg::xlen - 13){iw.b_view.imm12}},
    iw.b_view.imm12,
    iw.b_view.imm11,
    iw.b_view.imm10_5,
    iw.b_view.imm4_1,
    1'b0
  };

  // J offset, 21 bits signed
  assign j_off = {
    {(fetch_pkg::xlen - 21){iw.j_view.imm20}},
    iw.j_view.imm20,
    iw.j_view.imm19_12,
    iw.j_view.imm11,
    iw.j_view.imm10_1,
    1'b0
  };

  assign off = is_jal ? j_off : b_off;

  always_comb begin
    pred.target = pkt.pc + off;
    // JAL always taken
    if (is_jal) begin
      pred.taken = pkt.valid;
    end else if (is_branch) begin
      // Backward taken, forward not taken; sign is imm12
      pred.taken = pkt.valid & iw.b_view.imm12;
    end else begin
      // JALR and the rest fall through
      pred.taken = 1'b0;
    end
  end

endmodule

// File: hw/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall,
  input  logic                  flush,
  input  fetch_pkg::fetch_pkt_t pkt,
  input  fetch_pkg::pred_t      pred,
  output fetch_pkg::id_pkt_t    id
);

  logic                       valid_q;
  logic [fetch_pkg::xlen-1:0] pc_q;
  logic [fetch_pkg::xlen-1:0] pc_plus4_q;
  logic [31:0]                instr_q;
  fetch_pkg::pred_t           pred_q;

  // Payload follows the packet whenever the pipe moves
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q       <= pkt.pc;
      pc_plus4_q <= pkt.pc + fetch_pkg::xlen'(4);
      instr_q    <= pkt.instr;
      pred_q     <= pred;
    end
  end

  // Flush wins over stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= pkt.valid;
    end
  end

  // Decode stage view
  assign id.valid    = valid_q;
  assign id.pc       = pc_q;
  assign id.pc_plus4 = pc_plus4_q;
  assign id.instr    = instr_q;
  assign id.pred     = pred_q;

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter int IMEM_AW = 6
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stall,
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::xlen-1:0] redirect_target,
  input  logic                       imem_we,
  input  logic [IMEM_AW-1:0]         imem_waddr,
  input  logic [31:0]                imem_wdata,
  output fetch_pkg::id_pkt_t         id
);

  // PC to memory
  fetch_pkg::fetch_req_t req;
  // Memory to predecoder and IF/ID
  fetch_pkg::fetch_pkt_t pkt;
  // Prediction, back to the PC and on to decode
  fetch_pkg::pred_t      pred;
  // Kill of the fall-through fetch
  logic                  squash;

  // Next PC and PC register
  pc_gen u_pc_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall           (stall),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .pkt_valid       (pkt.valid),
    .pred            (pred),
    .req             (req),
    .squash          (squash)
  );

  // One-cycle instruction memory
  imem_bram #(
    .IMEM_AW (IMEM_AW)
  ) u_imem (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .squash         (squash),
    .req            (req),
    .we             (imem_we),
    .waddr          (imem_waddr),
    .wdata          (imem_wdata),
    .pkt            (pkt)
  );

  // Static predictor on the returned word
  branch_predecode u_predecode (
    .pkt  (pkt),
    .pred (pred)
  );

  // Redirect flushes IF/ID at the same edge
  if_id_reg u_if_id (
    .clk   (clk),
    .rst_n (rst_n),
    .stall (stall),
    .flush (redirect_valid),
    .pkt   (pkt),
    .pred  (pred),
    .id    (id)
  );

endmodule

// File: tests/fetch_tb_table.svh
`ifndef FETCH_TB_TABLE_SVH
`define FETCH_TB_TABLE_SVH

// Program words by byte address, every other word gets the fill pattern
localparam prog_entry_t prog [11] = '{
  '{8'h00, 32'h0010_0093},  // addi x1, x0, 1
  '{8'h04, 32'h0020_0113},  // addi x2, x0, 2
  '{8'h08, 32'h0000_0463},  // beq x0, x0, +8 forward
  '{8'h0c, 32'h0000_8067},  // jalr x0, 0(x1)
  '{8'h10, 32'h0030_0193},  // addi x3, x0, 3
  '{8'h14, 32'h00c0_006f},  // jal x0, +12
  '{8'h1c, 32'h0050_0293},  // addi x5, x0, 5
  '{8'h20, 32'h0060_0313},  // addi x6, x0, 6
  '{8'h24, 32'hfe00_9ee3},  // bne x1, x0, -4 backward
  '{8'h40, 32'h0070_0393},  // addi x7, x0, 7
  '{8'h44, 32'hfbdf_f06f}   // jal x0, -68 backward
};

// Columns: stall, redirect, redirect target, expected pc, expected taken, expected target
// Each row expects the next new valid entry at the decode stage
localparam row_t rows [17] = '{
  '{1'b0, 1'b0, 32'h00, 32'h00, 1'b0, 32'h00},  // first fetch after reset
  '{1'b0, 1'b0, 32'h00, 32'h04, 1'b0, 32'h00},
  '{1'b1, 1'b0, 32'h00, 32'h08, 1'b0, 32'h00},  // forward beq, not taken
  '{1'b0, 1'b0, 32'h00, 32'h0c, 1'b0, 32'h00},  // jalr, not taken
  '{1'b0, 1'b0, 32'h00, 32'h10, 1'b0, 32'h00},
  '{1'b0, 1'b0, 32'h00, 32'h14, 1'b1, 32'h20},  // jal forward
  '{1'b0, 1'b0, 32'h00, 32'h20, 1'b0, 32'h00},
  '{1'b1, 1'b0, 32'h00, 32'h24, 1'b1, 32'h20},  // stall with the bne prediction pending
  '{1'b0, 1'b0, 32'h00, 32'h20, 1'b0, 32'h00},
  '{1'b0, 1'b1, 32'h40, 32'h40, 1'b0, 32'h00},  // redirect beats the bne prediction
  '{1'b0, 1'b0, 32'h00, 32'h44, 1'b1, 32'h00},  // jal backward
  '{1'b0, 1'b0, 32'h00, 32'h00, 1'b0, 32'h00},
  '{1'b0, 1'b0, 32'h00, 32'h04, 1'b0, 32'h00},
  '{1'b1, 1'b1, 32'h1c, 32'h1c, 1'b0, 32'h00},  // redirect while stalled
  '{1'b0, 1'b0, 32'h00, 32'h20, 1'b0, 32'h00},
  '{1'b0, 1'b0, 32'h00, 32'h24, 1'b1, 32'h20},
  '{1'b0, 1'b0, 32'h00, 32'h20, 1'b0, 32'h00}
};

`endif

// File: tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int imem_aw = 6;

  // One program word at a byte address
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] word;
  } prog_entry_t;

  // Stimulus for one step and the decode-stage entry it must produce
  typedef struct packed {
    logic        stall_en;
    logic        redir;
    logic [31:0] redir_pc;
    logic [31:0] exp_pc;
    logic        exp_taken;
    logic [31:0] exp_target;
  } row_t;

  `include "fetch_tb_table.svh"

  logic               clk;
  logic               rst_n;
  logic               stall;
  logic               redirect_valid;
  logic [31:0]        redirect_target;
  logic               imem_we;
  logic [imem_aw-1:0] imem_waddr;
  logic [31:0]        imem_wdata;
  fetch_pkg::id_pkt_t id;

  // High when the last edge let IF/ID move
  logic moved;
  int   errors;
  int   row_errs;
  int   rows_run;
  int   rows_failed;

  fetch_top #(.IMEM_AW(imem_aw)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected memory image with addi x0 of the word index as fill
  function automatic logic [31:0] image_word(input int idx);
    logic [31:0] w;
    w = 32'h0000_0013 | (32'(idx) << 20);
    for (int i = 0; i < $size(prog); i++) begin
      if (int'(prog[i].addr[7:2]) == idx) begin
        w = prog[i].word;
      end
    end
    return w;
  endfunction

  // One rising edge and the 2 ns drive delay after it
  task automatic tick();
    @(posedge clk);
    moved = !stall;
    #2;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    row_errs++;
  endtask

  // Step until IF/ID takes a new valid entry within 20 edges
  task automatic wait_new_id(output logic found);
    int cycles;
    found = 1'b0;
    cycles = 0;
    while (!found && cycles < 20) begin
      tick();
      cycles++;
      found = moved && id.valid;
    end
  endtask

  initial begin
    int          n;
    logic        found;
    logic        aborted;
    logic [31:0] exp_plus4;
    logic [31:0] exp_instr;
    row_t        r;
    void'($urandom(32'h65c2));
    rst_n = 1'b0;
    stall = 1'b1;
    redirect_valid = 1'b0;
    redirect_target = '0;
    imem_we = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    moved = 1'b0;
    errors = 0;
    rows_run = 0;
    rows_failed = 0;
    aborted = 1'b0;
    // Whole memory written under stall with reset dropped after the fourth edge
    for (int a = 0; a < 2 ** imem_aw; a++) begin
      imem_we = 1'b1;
      imem_waddr = imem_aw'(a);
      imem_wdata = image_word(a);
      tick();
      if (a == 3) begin
        rst_n = 1'b1;
      end
    end
    imem_we = 1'b0;
    for (int i = 0; i < $size(rows) && !aborted; i++) begin
      r = rows[i];
      row_errs = 0;
      n = r.stall_en ? 1 + int'($urandom() % 4) : 0;
      stall = (n > 0);
      redirect_valid = r.redir;
      redirect_target = r.redir_pc;
      // Redirect pulse lasts one edge and stall lasts n edges
      if (n > 0 || r.redir) begin
        tick();
        redirect_valid = 1'b0;
        // Flush at the redirect edge keeps the old-path entry out of decode
        if (moved && id.valid) begin
          $display("row %0d: a stale entry at pc %h reached decode at the redirect edge",
                   i, id.pc);
          row_errs++;
        end
        for (int k = 1; k < n; k++) begin
          tick();
        end
        stall = 1'b0;
      end
      wait_new_id(found);
      rows_run++;
      if (!found) begin
        $display("row %0d: no valid entry reached decode within 20 cycles", i);
        row_errs++;
        aborted = 1'b1;
      end else begin
        exp_plus4 = r.exp_pc + 32'd4;
        exp_instr = image_word(int'(r.exp_pc[7:2]));
        if (id.pc !== r.exp_pc) begin
          report_mismatch("id.pc", r.exp_pc, id.pc);
        end
        if (id.pc_plus4 !== exp_plus4) begin
          report_mismatch("id.pc_plus4", exp_plus4, id.pc_plus4);
        end
        if (id.instr !== exp_instr) begin
          report_mismatch("id.instr", exp_instr, id.instr);
        end
        if (id.pred.taken !== r.exp_taken) begin
          report_mismatch("id.pred.taken", 32'(r.exp_taken), 32'(id.pred.taken));
        end
        if (r.exp_taken && id.pred.target !== r.exp_target) begin
          report_mismatch("id.pred.target", r.exp_target, id.pred.target);
        end
      end
      if (row_errs != 0) begin
        rows_failed++;
        errors += row_errs;
      end
      $display("row %0d pc %h: %s", i, r.exp_pc, row_errs == 0 ? "pass" : "fail");
    end
    $display("%0d rows run, %0d passed, %0d failed, %0d errors",
             rows_run, rows_run - rows_failed, rows_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+tests
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/imem_bram.sv
hw/branch_predecode.sv
hw/if_id_reg.sv
hw/fetch_top.sv
tests/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass when the log holds the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f list.f --top-module fetch_tb -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
